//--- verilog/gx_video_pkg.sv
package gx_video_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry and address map
    //////////////////////////////////////////////////////////////////////

    // Width of the h and v beam counters
    localparam int POS_WIDTH = 9;

    // Palette window 7F60..7F6B
    localparam logic [7:0] PAL_PAGE    = 8'h7F;
    localparam logic [3:0] PAL_NIBBLE  = 4'h6;
    localparam int         PAL_ENTRIES = 12;

    // Mode register decoded on the low byte only
    localparam logic [7:0] MODE_ADDR = 8'h82;

    // One cycle each for beam, palette and effect stage
    localparam int PIPE_LATENCY = 3;

    //////////////////////////////////////////////////////////////////////
    // Pixel and bus types
    //////////////////////////////////////////////////////////////////////

    // One colour intensity
    typedef logic [1:0] level_t;

    typedef struct packed {
        level_t r;
        level_t g;
        level_t b;
    } rgb_t;

    // CPU write port with a single-cycle strobe
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        wr;
    } cpu_bus_t;

    // Entries 0-3 red, 4-7 green, 8-11 blue
    typedef level_t [PAL_ENTRIES-1:0] palette_t;

    // Unlisted codes behave as normal
    typedef enum logic [7:0] {
        MODE_NORMAL       = 8'd0,
        MODE_DOUBLE_WIDTH = 8'd1,
        MODE_BLANK_ODD    = 8'd2,
        MODE_SCANLINE     = 8'd3,
        MODE_SHADOW       = 8'd4
    } video_mode_t;

    // One pixel travelling down the pipeline
    typedef struct packed {
        rgb_t pix;
        logic active;
        logic enhanced;
        logic h_odd;
        logic v_odd;
        logic first_of_line;
    } beam_t;

endpackage

//--- verilog/gx_cpu_regs.sv
`timescale 1ns/1ns

module gx_cpu_regs (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     gx4000_mode,
    input  gx_video_pkg::cpu_bus_t   cpu,
    output gx_video_pkg::palette_t   palette,
    output gx_video_pkg::video_mode_t mode
);

    gx_video_pkg::palette_t    palette_q;
    gx_video_pkg::video_mode_t mode_q;

    logic wr_en;
    logic mode_hit;
    logic pal_hit;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // Writes only count in GX4000 mode
    assign wr_en = cpu.wr && gx4000_mode;

    assign mode_hit = wr_en && (cpu.addr[7:0] == gx_video_pkg::MODE_ADDR);

    // Upper four slots of the window are not backed by entries
    assign pal_hit = wr_en
                  && (cpu.addr[15:8] == gx_video_pkg::PAL_PAGE)
                  && (cpu.addr[7:4] == gx_video_pkg::PAL_NIBBLE)
                  && (cpu.addr[3:0] < gx_video_pkg::PAL_ENTRIES);

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            palette_q <= '0;
            mode_q    <= gx_video_pkg::MODE_NORMAL;
        end else begin
            if (mode_hit) begin
                mode_q <= gx_video_pkg::video_mode_t'(cpu.data);
            end
            // Only the low two data bits are a level
            if (pal_hit) begin
                palette_q[cpu.addr[3:0]] <= cpu.data[1:0];
            end
        end
    end

    assign palette = palette_q;
    assign mode    = mode_q;

    // Tables and mode hold unless a qualified write was sampled
    a_hold_without_write: assert property (
        @(posedge clk_sys) disable iff (reset)
        !wr_en |=> ($stable(palette_q) && $stable(mode_q))
    );

endmodule

//--- verilog/gx_beam_counter.sv
`timescale 1ns/1ns

module gx_beam_counter (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 gx4000_mode,
    input  gx_video_pkg::rgb_t   video_in,
    input  logic                 hblank,
    input  logic                 vblank,
    output gx_video_pkg::beam_t  beam
);

    logic [gx_video_pkg::POS_WIDTH-1:0] h_count;
    logic [gx_video_pkg::POS_WIDTH-1:0] v_count;
    logic [gx_video_pkg::POS_WIDTH-1:0] h_pos;
    logic                               hblank_d;
    logic                               hblank_rise;

    gx_video_pkg::beam_t beam_q;

    //////////////////////////////////////////////////////////////////////
    // Beam position
    //////////////////////////////////////////////////////////////////////

    // Position of the pixel on the inputs right now
    assign h_pos = hblank ? '0 : h_count;

    // Line ends on the first blanking cycle
    assign hblank_rise = hblank && !hblank_d;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            h_count  <= '0;
            v_count  <= '0;
            hblank_d <= 1'b0;
        end else begin
            hblank_d <= hblank;
            if (hblank) begin
                h_count <= '0;
            end else begin
                h_count <= h_count + 1'b1;
            end
            // First line after vblank stays at zero, so it is even
            if (vblank) begin
                v_count <= '0;
            end else if (hblank_rise) begin
                v_count <= v_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1 item
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            beam_q <= '0;
        end else begin
            beam_q.pix           <= video_in;
            beam_q.active        <= !hblank && !vblank;
            beam_q.enhanced      <= gx4000_mode;
            beam_q.h_odd         <= h_pos[0];
            beam_q.v_odd         <= v_count[0];
            beam_q.first_of_line <= (h_pos == '0);
        end
    end

    assign beam = beam_q;

    // Counter is already cleared on every blanking cycle after the first
    a_hblank_zero: assert property (
        @(posedge clk_sys) disable iff (reset)
        (hblank && hblank_d) |-> (h_count == '0)
    );

endmodule

//--- verilog/gx_palette_stage.sv
`timescale 1ns/1ns

module gx_palette_stage (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  gx_video_pkg::palette_t palette,
    input  gx_video_pkg::beam_t    beam_in,
    output gx_video_pkg::beam_t    beam_out
);

    gx_video_pkg::beam_t mapped;
    gx_video_pkg::beam_t beam_q;

    // Table select in the upper index bits, level in the lower
    function automatic gx_video_pkg::level_t lookup(
        input gx_video_pkg::palette_t pal,
        input logic [1:0]             tbl,
        input gx_video_pkg::level_t   lvl
    );
        logic [3:0] idx;
        idx = {tbl, lvl};
        return pal[idx];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Per-channel remap
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mapped = beam_in;
        // Raw and blank items keep their pixel for the output select
        if (beam_in.active && beam_in.enhanced) begin
            mapped.pix.r = lookup(palette, 2'd0, beam_in.pix.r);
            mapped.pix.g = lookup(palette, 2'd1, beam_in.pix.g);
            mapped.pix.b = lookup(palette, 2'd2, beam_in.pix.b);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            beam_q <= '0;
        end else begin
            beam_q <= mapped;
        end
    end

    assign beam_out = beam_q;

endmodule

//--- verilog/gx_effect_stage.sv
`timescale 1ns/1ns

module gx_effect_stage (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  gx_video_pkg::video_mode_t mode,
    input  gx_video_pkg::beam_t       beam,
    output gx_video_pkg::rgb_t        video_out
);

    gx_video_pkg::rgb_t out_q;
    gx_video_pkg::rgb_t effect_pix;
    gx_video_pkg::rgb_t halved;
    gx_video_pkg::rgb_t next_pix;
    logic               repeat_pix;

    // Dim all three channels by one step
    function automatic gx_video_pkg::rgb_t halve(input gx_video_pkg::rgb_t p);
        gx_video_pkg::rgb_t h;
        h.r = p.r >> 1;
        h.g = p.g >> 1;
        h.b = p.b >> 1;
        return h;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Effects
    //////////////////////////////////////////////////////////////////////

    assign halved = halve(beam.pix);

    // Line start is always even, so this never reaches into the last line
    assign repeat_pix = beam.h_odd && !beam.first_of_line;

    always_comb begin
        case (mode)
            gx_video_pkg::MODE_DOUBLE_WIDTH: begin
                // Output register still holds the even neighbour
                effect_pix = repeat_pix ? out_q : beam.pix;
            end
            gx_video_pkg::MODE_BLANK_ODD: begin
                effect_pix = beam.v_odd ? '0 : beam.pix;
            end
            gx_video_pkg::MODE_SCANLINE: begin
                effect_pix = beam.v_odd ? halved : beam.pix;
            end
            gx_video_pkg::MODE_SHADOW: begin
                effect_pix = halved;
            end
            default: begin
                effect_pix = beam.pix;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output select and register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!beam.enhanced) begin
            next_pix = beam.pix;
        end else if (!beam.active) begin
            next_pix = '0;
        end else begin
            next_pix = effect_pix;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            out_q <= '0;
        end else begin
            out_q <= next_pix;
        end
    end

    assign video_out = out_q;

    // Enhanced blanking is black whatever mode is set
    a_blank_black: assert property (
        @(posedge clk_sys) disable iff (reset)
        (beam.enhanced && !beam.active) |=> (out_q == '0)
    );

endmodule

//--- verilog/gx_video_top.sv
`timescale 1ns/1ns

module gx_video_top (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   gx4000_mode,
    input  gx_video_pkg::cpu_bus_t cpu,
    input  gx_video_pkg::rgb_t     video_in,
    input  logic                   hblank,
    input  logic                   vblank,
    output gx_video_pkg::rgb_t     video_out
);

    gx_video_pkg::palette_t    palette;
    gx_video_pkg::video_mode_t mode;

    // Pipeline items after stage 1 and stage 2
    gx_video_pkg::beam_t s1;
    gx_video_pkg::beam_t s2;

    gx_cpu_regs i_gx_cpu_regs (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .cpu         (cpu),
        .palette     (palette),
        .mode        (mode)
    );

    gx_beam_counter i_gx_beam_counter (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .video_in    (video_in),
        .hblank      (hblank),
        .vblank      (vblank),
        .beam        (s1)
    );

    gx_palette_stage i_gx_palette_stage (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .palette  (palette),
        .beam_in  (s1),
        .beam_out (s2)
    );

    gx_effect_stage i_gx_effect_stage (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .mode      (mode),
        .beam      (s2),
        .video_out (video_out)
    );

endmodule

//--- sim/tb_gx_video.sv
`timescale 1ns/1ns

module tb_gx_video;

    // Each frame has 2 vblank lines and 4 visible lines of 8 pixels plus 2 hblank cycles
    localparam int LINE_ACTIVE   = 8;
    localparam int LINE_CYCLES   = LINE_ACTIVE + 2;
    localparam int VBLANK_LINES  = 2;
    localparam int VISIBLE_LINES = 4;
    localparam int FRAME_CYCLES  = (VBLANK_LINES + VISIBLE_LINES) * LINE_CYCLES
                                 + gx_video_pkg::PIPE_LATENCY;
    localparam int NUM_FRAMES    = 7;
    localparam int RESET_CYCLES  = 16;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + 2 * NUM_FRAMES * FRAME_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'h9d26;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                   clk_sys = 1'b0;
    logic                   reset;
    logic                   gx4000_mode;
    gx_video_pkg::cpu_bus_t cpu;
    gx_video_pkg::rgb_t     video_in;
    logic                   hblank;
    logic                   vblank;
    gx_video_pkg::rgb_t     video_out;

    // Reference model state
    logic                               gx_on;
    gx_video_pkg::palette_t             model_pal;
    gx_video_pkg::video_mode_t          model_mode;
    logic [gx_video_pkg::POS_WIDTH-1:0] model_h;
    logic [gx_video_pkg::POS_WIDTH-1:0] model_v;
    logic                               model_hb_prev;
    gx_video_pkg::rgb_t                 model_prev;
    gx_video_pkg::rgb_t                 expect_q[$];

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors = 0;

    gx_video_top i_gx_video_top (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .gx4000_mode (gx4000_mode),
        .cpu         (cpu),
        .video_in    (video_in),
        .hblank      (hblank),
        .vblank      (vblank),
        .video_out   (video_out)
    );

    always #2 clk_sys = ~clk_sys;

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic gx_video_pkg::rgb_t random_pixel();
        logic [7:0] v;
        v = random_bits(6);
        return gx_video_pkg::rgb_t'(v[5:0]);
    endfunction

    // One step darker on every channel
    function automatic gx_video_pkg::rgb_t dim_pixel(input gx_video_pkg::rgb_t p);
        gx_video_pkg::rgb_t d;
        d.r = {1'b0, p.r[1]};
        d.g = {1'b0, p.g[1]};
        d.b = {1'b0, p.b[1]};
        return d;
    endfunction

    task automatic check_rgb(input gx_video_pkg::rgb_t expected,
                             input gx_video_pkg::rgb_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("mismatch video_out expected %h actual %h", expected, actual);
        end
    endtask

    // Drives one cycle, runs the model on it and checks the item from 3 cycles back
    task automatic drive_cycle(
        input gx_video_pkg::rgb_t     pix,
        input logic                   hb,
        input logic                   vb,
        input gx_video_pkg::cpu_bus_t bus
    );
        gx_video_pkg::rgb_t mapped;
        gx_video_pkg::rgb_t want;
        logic               h_odd;
        logic               v_odd;
        @(posedge clk_sys);
        gx4000_mode <= gx_on;
        cpu         <= bus;
        video_in    <= pix;
        hblank      <= hb;
        vblank      <= vb;

        // A write already applies to the pixel sent with it
        if (bus.wr && gx_on) begin
            if (bus.addr[7:0] == gx_video_pkg::MODE_ADDR) begin
                model_mode = gx_video_pkg::video_mode_t'(bus.data);
            end
            if (bus.addr[15:8] == gx_video_pkg::PAL_PAGE
                    && bus.addr[7:4] == gx_video_pkg::PAL_NIBBLE
                    && int'(bus.addr[3:0]) < gx_video_pkg::PAL_ENTRIES) begin
                model_pal[bus.addr[3:0]] = bus.data[1:0];
            end
        end

        h_odd = hb ? 1'b0 : model_h[0];
        v_odd = model_v[0];
        model_h = hb ? '0 : model_h + 1'b1;
        if (vb) begin
            model_v = '0;
        end else if (hb && !model_hb_prev) begin
            model_v = model_v + 1'b1;
        end
        model_hb_prev = hb;

        mapped.r = model_pal[int'(pix.r)];
        mapped.g = model_pal[int'(pix.g) + 4];
        mapped.b = model_pal[int'(pix.b) + 8];
        want = '0;
        if (!gx_on) begin
            want = pix;
        end else if (!hb && !vb) begin
            case (model_mode)
                gx_video_pkg::MODE_DOUBLE_WIDTH: want = h_odd ? model_prev : mapped;
                gx_video_pkg::MODE_BLANK_ODD:    want = v_odd ? want : mapped;
                gx_video_pkg::MODE_SCANLINE:     want = v_odd ? dim_pixel(mapped) : mapped;
                gx_video_pkg::MODE_SHADOW:       want = dim_pixel(mapped);
                default:                         want = mapped;
            endcase
        end
        model_prev = want;
        expect_q.push_back(want);

        @(negedge clk_sys);
        if (expect_q.size() > gx_video_pkg::PIPE_LATENCY) begin
            check_rgb(expect_q.pop_front(), video_out);
        end
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        gx_video_pkg::cpu_bus_t bus;
        bus.addr = addr;
        bus.data = data;
        bus.wr   = 1'b1;
        drive_cycle('0, 1'b1, 1'b1, bus);
    endtask

    task automatic stream_frame();
        for (int line = 0; line < VBLANK_LINES + VISIBLE_LINES; line++) begin
            for (int x = 0; x < LINE_CYCLES; x++) begin
                drive_cycle(random_pixel(), x >= LINE_ACTIVE, line < VBLANK_LINES, '0);
            end
        end
        // Blank tail flushes the pipeline
        for (int i = 0; i < gx_video_pkg::PIPE_LATENCY; i++) begin
            drive_cycle(random_pixel(), 1'b1, 1'b1, '0);
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic passthrough_after_reset();
        @(negedge clk_sys);
        check_rgb('0, video_out);
        stream_frame();
        report_test("passthrough_after_reset");
    endtask

    task automatic palette_mapping();
        gx_on = 1'b1;
        cpu_write({8'h00, gx_video_pkg::MODE_ADDR}, 8'(gx_video_pkg::MODE_NORMAL));
        for (int i = 0; i < gx_video_pkg::PAL_ENTRIES; i++) begin
            cpu_write({gx_video_pkg::PAL_PAGE, gx_video_pkg::PAL_NIBBLE, 4'(i)}, random_bits(8));
        end
        stream_frame();
        report_test("palette_mapping");
    endtask

    task automatic ignored_writes();
        gx_on = 1'b0;
        for (int i = 0; i < 4; i++) begin
            cpu_write({gx_video_pkg::PAL_PAGE, gx_video_pkg::PAL_NIBBLE, 4'(i)}, random_bits(8));
        end
        cpu_write({8'h00, gx_video_pkg::MODE_ADDR}, 8'(gx_video_pkg::MODE_SHADOW));
        gx_on = 1'b1;
        // Unbacked slots 12 to 15 of the window
        for (int i = 12; i < 16; i++) begin
            cpu_write({gx_video_pkg::PAL_PAGE, gx_video_pkg::PAL_NIBBLE, 4'(i)}, random_bits(8));
        end
        cpu_write(16'h7E60, random_bits(8));
        cpu_write(16'h7F50, random_bits(8));
        cpu_write(16'h7F81, 8'(gx_video_pkg::MODE_SHADOW));
        stream_frame();
        report_test("ignored_writes");
    endtask

    task automatic line_effects();
        gx_video_pkg::video_mode_t modes[3];
        modes[0] = gx_video_pkg::MODE_BLANK_ODD;
        modes[1] = gx_video_pkg::MODE_SCANLINE;
        modes[2] = gx_video_pkg::MODE_SHADOW;
        for (int i = 0; i < 3; i++) begin
            cpu_write({8'h00, gx_video_pkg::MODE_ADDR}, 8'(modes[i]));
            stream_frame();
        end
        report_test("line_effects");
    endtask

    task automatic double_width();
        cpu_write({8'h00, gx_video_pkg::MODE_ADDR}, 8'(gx_video_pkg::MODE_DOUBLE_WIDTH));
        stream_frame();
        report_test("double_width");
    endtask

    initial begin
        reset       <= 1'b1;
        gx4000_mode <= 1'b0;
        cpu         <= '0;
        video_in    <= '0;
        hblank      <= 1'b1;
        vblank      <= 1'b1;
        lfsr_state    = LFSR_SEED;
        gx_on         = 1'b0;
        model_pal     = '0;
        model_mode    = gx_video_pkg::MODE_NORMAL;
        model_h       = '0;
        model_v       = '0;
        model_prev    = '0;
        // First edge after reset samples the held blank inputs
        model_hb_prev = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;

        passthrough_after_reset();
        palette_mapping();
        ignored_writes();
        line_effects();
        double_width();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
verilog/gx_video_pkg.sv
verilog/gx_cpu_regs.sv
verilog/gx_beam_counter.sv
verilog/gx_palette_stage.sv
verilog/gx_effect_stage.sv
verilog/gx_video_top.sv
sim/tb_gx_video.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_gx_video \
    -f all.f -o tb_gx_video > build.log 2>&1 \
    && ./obj_dir/tb_gx_video > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
